// File: verilog.f
+incdir+common
common/sync_pkg.sv
pco/pco_trigger.sv
pco/pco_core.sv
controller/duty_ctrl.sv
design/pulse_gen.sv
design/sync_node_top.sv
sim/tb_sync_node.sv

// File: sim/tb_sync_node.sv
// testbench for the pco sync node, runs natural, coupled and slave phases under assertion checks
`timescale 1ns/100ps
`default_nettype none

`include "pco_config.svh"

module tb_sync_node;

	localparam sync_pkg::cnt_t NDELAY    = 20;
	localparam sync_pkg::cnt_t NPCO      = 12;
	localparam sync_pkg::cnt_t NCSTR     = 5;
	localparam sync_pkg::cnt_t NBLACKOUT = 3;
	localparam sync_pkg::cnt_t NPULSE    = 3;
	localparam sync_pkg::cnt_t NDUTY     = 2;
	localparam sync_pkg::cnt_t NDUTY_LO  = 2;
	localparam sync_pkg::cnt_t NDUTY_HI  = 6;
	localparam sync_pkg::seq_t ENCODED   = 64'h9e37_79b9_7f4a_7c15;
	localparam int NAT_PERIOD   = NDELAY + NPCO * (NPCO - 1) / 2; // cycles between natural resets
	localparam int IDX_LAST     = (1 << `SEQ_IDX_BITS) - 1;
	localparam int WATCHDOG_CYC = 4 * 12 * NAT_PERIOD + 500; // 4 phases, up to 12 periods each

	logic clk = 1'b0;
	logic greset_n;
	logic run;
	logic peak;
	logic design_sel;
	logic pco_pulse;
	logic pco_forced;
	logic duty_out;
	logic seq_out;
	sync_pkg::ctrl_state_e state;
	sync_pkg::cnt_t        phase;
	sync_pkg::cnt_t        cpl_phase; // phase when a coupling pulse lands
	integer     seed = 3786;
	int         err_cnt = 0;
	int         cyc, last_pulse, last_peak, cpl_at, pulse_gap;
	int         lead_t, slave_t, idx_cur, idx_nxt; // expected tallies and sequence index
	logic       have_last, quiet, peak_d, lead_done, slave_done;
	logic       in_sync, duty_cond;
	logic [1:0] cpl_kind; // 0 none, 1 blackout, 2 jump, 3 forced

	always #2 clk = ~clk; // 4 ns period

	assign in_sync   = (state == sync_pkg::sync_lead) || (state == sync_pkg::sync_slave);
	assign duty_cond = in_sync && (phase >= NDUTY_LO) && (phase <= NDUTY_HI);

	sync_node_top DUT (
		.clk        (clk),
		.greset_n   (greset_n),
		.run        (run),
		.peak       (peak),
		.design_sel (design_sel),
		.ndelay     (NDELAY),
		.nblackout  (NBLACKOUT),
		.ncstr      (NCSTR),
		.npco       (NPCO),
		.nduty_lo   (NDUTY_LO),
		.nduty_hi   (NDUTY_HI),
		.npulse     (NPULSE),
		.nduty      (NDUTY),
		.encoded    (ENCODED),
		.pco_pulse  (pco_pulse),
		.pco_forced (pco_forced),
		.duty_out   (duty_out),
		.seq_out    (seq_out),
		.state      (state),
		.phase      (phase)
	);

	task automatic fail_check(input string msg);
		err_cnt++;
		$display("[ERROR] %0t ns: %s", $time, msg);
		$display("Result: FAILED");
		$fatal(1, "stopping at first error");
	endtask

	// expected behavior tracked mid-cycle, outputs are settled here
	always @(negedge clk) begin
		if (!greset_n) begin
			cyc        = 0;
			last_pulse = 0;
			last_peak  = -1000;
			cpl_at     = -1;
			cpl_kind   = 2'd0;
			have_last  = 1'b0;
			quiet      = 1'b0;
			peak_d     = 1'b0;
			lead_t     = 0;
			slave_t    = 0;
			lead_done  = 1'b0;
			slave_done = 1'b0;
			idx_cur    = IDX_LAST;
			idx_nxt    = IDX_LAST; // sequence idle
		end else begin
			cyc++;
			if (peak && !peak_d) cpl_at = cyc + 2; // edge reaches the pco two edges later
			if (peak) last_peak = cyc;
			peak_d   = peak;
			cpl_kind = 2'd0;
			if (cyc == cpl_at) begin
				cpl_phase = phase;
				if (phase <= NBLACKOUT) cpl_kind = 2'd1;
				else if (phase + NCSTR >= NPCO) cpl_kind = 2'd3;
				else cpl_kind = 2'd2;
			end
			quiet = 1'b0;
			if (pco_pulse) begin
				pulse_gap  = cyc - last_pulse;
				quiet      = have_last && (cyc - last_peak > pulse_gap + 3); // no peak in between
				last_pulse = cyc;
				have_last  = 1'b1;
			end
			lead_done  = 1'b0;
			slave_done = 1'b0;
			if (state != sync_pkg::desync) begin
				lead_t  = 0; // tallies start fresh on each entry to desync
				slave_t = 0;
			end else if (pco_pulse && pco_forced && (phase > NDUTY_HI)) begin
				slave_t++;
				slave_done = (slave_t == NPULSE);
			end else if (pco_pulse && pco_forced) begin
				lead_t  = 0;
				slave_t = 0;
			end else if (pco_pulse) begin
				lead_t++;
				lead_done = (lead_t == NPULSE);
			end
			idx_cur = idx_nxt;
			if (pco_pulse && (idx_cur == IDX_LAST)) idx_nxt = 0; // pulse mid-sequence is dropped
			else if (idx_cur != IDX_LAST) idx_nxt = idx_cur + 1;
		end
	end

	a_reset: assert property (@(posedge clk) !greset_n |=> (!duty_out && !pco_pulse
		&& (state == sync_pkg::idle) && (phase == 1)))
		else fail_check("outputs not at their reset values");
	a_period: assert property (@(posedge clk) disable iff (!greset_n)
		(pco_pulse && quiet) |-> ((pulse_gap == NAT_PERIOD) && !pco_forced))
		else fail_check("natural reset period or forced flag wrong");
	a_forced: assert property (@(posedge clk) disable iff (!greset_n)
		(cpl_kind == 2'd3) |-> (pco_pulse && pco_forced) ##1 (phase == 1))
		else fail_check("late coupling pulse gave no forced reset");
	a_jump: assert property (@(posedge clk) disable iff (!greset_n)
		(cpl_kind == 2'd2) |-> !pco_pulse ##1 (phase == cpl_phase + NCSTR))
		else fail_check("coupling pulse did not advance phase by ncstr");
	a_blackout: assert property (@(posedge clk) disable iff (!greset_n)
		(cpl_kind == 2'd1) |-> !pco_pulse ##1 ((phase == cpl_phase) || (phase == cpl_phase + 1)))
		else fail_check("peak inside the blackout changed the pco");
	a_lead: assert property (@(posedge clk) disable iff (!greset_n)
		lead_done |-> ##2 (state == sync_pkg::sync_lead))
		else fail_check("state not sync_lead after npulse natural resets");
	a_slave: assert property (@(posedge clk) disable iff (!greset_n)
		slave_done |-> ##2 (state == sync_pkg::sync_slave))
		else fail_check("state not sync_slave after npulse late forced resets");
	a_lead_loop: assert property (@(posedge clk) disable iff (!greset_n)
		(state == sync_pkg::sync_lead)
		|=> ((state == sync_pkg::sync_lead) || (state == sync_pkg::check_lead)))
		else fail_check("sync_lead left to a state other than check_lead");
	a_check_lead: assert property (@(posedge clk) disable iff (!greset_n)
		((state == sync_pkg::check_lead) && pco_pulse && !pco_forced)
		|=> (state == sync_pkg::sync_lead))
		else fail_check("natural reset in check_lead did not return to sync_lead");
	a_desync: assert property (@(posedge clk) disable iff (!greset_n)
		((state == sync_pkg::check_slave) && pco_pulse && !pco_forced)
		|=> (state == sync_pkg::desync))
		else fail_check("natural reset in check_slave did not return to desync");
	a_duty_on: assert property (@(posedge clk) disable iff (!greset_n) duty_cond |=> duty_out)
		else fail_check("duty_out low after a cycle inside the duty window");
	a_duty_off: assert property (@(posedge clk) disable iff (!greset_n) !duty_cond |=> !duty_out)
		else fail_check("duty_out high after a cycle outside the duty window");
	a_seq: assert property (@(posedge clk) disable iff (!greset_n)
		seq_out == ENCODED[idx_cur])
		else fail_check("seq_out differs from the expected encoded bit");

	task automatic wait_pulses(input int n);
		int seen;
		seen = 0;
		while (seen < n) begin
			@(negedge clk);
			if (pco_pulse) seen++;
		end
	endtask

	// one-cycle peaks at random gaps, many land in the blackout
	task automatic random_peaks(input int n);
		int gap;
		repeat (n) begin
			gap = 6 + ($unsigned($random(seed)) % 32);
			repeat (gap) @(posedge clk);
			peak <= 1'b1;
			@(posedge clk);
			peak <= 1'b0;
		end
	endtask

	// peak late in the period so the forced reset comes with phase above nduty_hi
	task automatic late_peak();
		int extra;
		extra = $unsigned($random(seed)) % 3;
		do @(negedge clk); while (phase < NPCO - NCSTR + 1);
		repeat (extra) @(posedge clk);
		@(posedge clk);
		peak <= 1'b1;
		@(posedge clk);
		peak <= 1'b0;
		do @(negedge clk); while (!pco_pulse);
	endtask

	initial begin
		greset_n   = 1'b0;
		run        = 1'b1;
		peak       = 1'b0;
		design_sel = 1'b0;
		repeat (10) @(posedge clk);
		greset_n <= 1'b1;
		wait_pulses(10);         // free running, lead lock and duty windows
		random_peaks(16);        // coupling, jumps and blackout
		repeat (14) late_peak(); // slave lock
		do @(negedge clk); while (state != sync_pkg::check_slave);
		do @(negedge clk); while (state != sync_pkg::desync); // leader gone
		wait_pulses(2);
		if (err_cnt == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_CYC * 4);
		$display("timeout: test did not finish within %0d cycles", WATCHDOG_CYC);
		$display("Result: FAILED");
		$fatal(1, "run timed out");
	end

endmodule

`default_nettype wire

// File: design/sync_node_top.sv
// top of the pco sync node, config values come in as static ports held by the user
`timescale 1ns/100ps
`default_nettype none

module sync_node_top (
	input  logic                  clk,
	input  logic                  greset_n,
	input  logic                  run,        // one enable for every block
	input  logic                  peak,       // coupling peak from outside
	input  logic                  design_sel,
	input  sync_pkg::cnt_t        ndelay,
	input  sync_pkg::cnt_t        nblackout,
	input  sync_pkg::cnt_t        ncstr,
	input  sync_pkg::cnt_t        npco,
	input  sync_pkg::cnt_t        nduty_lo,
	input  sync_pkg::cnt_t        nduty_hi,
	input  sync_pkg::cnt_t        npulse,
	input  sync_pkg::cnt_t        nduty,
	input  sync_pkg::seq_t        encoded,
	output logic                  pco_pulse,
	output logic                  pco_forced,
	output logic                  duty_out,
	output logic                  seq_out,
	output sync_pkg::ctrl_state_e state,
	output sync_pkg::cnt_t        phase
);

	sync_pkg::pco_event_t ev; // shared by controller and pulse generator

	assign pco_pulse  = ev.pulse;
	assign pco_forced = ev.forced;
	assign phase      = ev.phase;

	pco_core u_pco (
		.clk        (clk),
		.greset_n   (greset_n),
		.run        (run),
		.peak       (peak),
		.design_sel (design_sel),
		.nblackout  (nblackout),
		.ncstr      (ncstr),
		.npco       (npco),
		.ndelay     (ndelay),
		.ev         (ev)
	);

	// controller and pulse generator run side by side on the same pulses
	duty_ctrl u_ctrl (
		.clk      (clk),
		.greset_n (greset_n),
		.run      (run),
		.ev       (ev),
		.nduty_lo (nduty_lo),
		.nduty_hi (nduty_hi),
		.npulse   (npulse),
		.nduty    (nduty),
		.duty_out (duty_out),
		.state    (state)
	);

	pulse_gen u_pulse (
		.clk      (clk),
		.greset_n (greset_n),
		.run      (run),
		.ev       (ev),
		.encoded  (encoded),
		.seq_out  (seq_out)
	);

endmodule

`default_nettype wire

// File: design/pulse_gen.sv
// coupling pulse generator, plays the encoded sequence once after each pco pulse
`timescale 1ns/100ps
`default_nettype none

`include "pco_config.svh"

module pulse_gen (
	input  logic                 clk,
	input  logic                 greset_n,
	input  logic                 run,
	input  sync_pkg::pco_event_t ev,
	input  sync_pkg::seq_t       encoded,
	output logic                 seq_out
);

	localparam logic [`SEQ_IDX_BITS-1:0] IDX_LAST = '1;

	logic [`SEQ_IDX_BITS-1:0] idx; // sits at the last bit when idle

	assign seq_out = encoded[idx];

	// a pulse mid-sequence is dropped
	always_ff @(posedge clk) begin
		if (!greset_n) begin
			idx <= IDX_LAST;
		end else if (run) begin
			if (ev.pulse && (idx == IDX_LAST)) begin
				idx <= '0;
			end else if (idx != IDX_LAST) begin
				idx <= idx + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: controller/duty_ctrl.sv
// duty-cycling controller, tracks pco resets to pick lead or slave and drives the duty window
`timescale 1ns/100ps
`default_nettype none

module duty_ctrl (
	input  logic                  clk,
	input  logic                  greset_n,
	input  logic                  run,
	input  sync_pkg::pco_event_t  ev,
	input  sync_pkg::cnt_t        nduty_lo,
	input  sync_pkg::cnt_t        nduty_hi,
	input  sync_pkg::cnt_t        npulse,
	input  sync_pkg::cnt_t        nduty,
	output logic                  duty_out,
	output sync_pkg::ctrl_state_e state
);

	sync_pkg::ctrl_state_e next_state;
	sync_pkg::cnt_t        cnt_lead;  // natural resets seen in desync
	sync_pkg::cnt_t        cnt_slave; // late forced resets seen in desync
	sync_pkg::cnt_t        cnt_duty;  // pco periods spent in a sync state
	logic                  natural_rst;
	logic                  forced_rst;
	logic                  in_sync;
	logic                  track_clr;
	logic                  duty_clr;

	assign natural_rst = ev.pulse && !ev.forced;
	assign forced_rst  = ev.pulse && ev.forced;
	assign in_sync     = (state == sync_pkg::sync_lead) || (state == sync_pkg::sync_slave);

	// duty window, one cycle behind its condition
	always_ff @(posedge clk) begin
		if (!greset_n) begin
			duty_out <= 1'b0;
		end else if (run) begin
			duty_out <= in_sync && (ev.phase >= nduty_lo) && (ev.phase <= nduty_hi);
		end
	end

	// reset tracker
	always_ff @(posedge clk) begin
		if (!greset_n) begin
			cnt_lead  <= '0;
			cnt_slave <= '0;
		end else if (run) begin
			if (track_clr) begin
				cnt_lead  <= '0;
				cnt_slave <= '0;
			end else if (state == sync_pkg::desync) begin
				if (forced_rst && (ev.phase > nduty_hi)) begin
					cnt_slave <= cnt_slave + 1'b1; // pulled in late, faster neighbour
				end else if (forced_rst) begin
					cnt_lead  <= '0; // early kick, likely a stray node
					cnt_slave <= '0;
				end else if (natural_rst) begin
					cnt_lead <= cnt_lead + 1'b1;
				end
			end
		end
	end

	// duty length counter, stops one past nduty
	always_ff @(posedge clk) begin
		if (!greset_n) begin
			cnt_duty <= '0;
		end else if (run) begin
			if (duty_clr) begin
				cnt_duty <= '0;
			end else if (ev.pulse && in_sync && (cnt_duty <= nduty)) begin
				cnt_duty <= cnt_duty + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!greset_n) begin
			state <= sync_pkg::idle;
		end else if (run) begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		track_clr  = 1'b0;
		duty_clr   = 1'b0;
		case (state)
			sync_pkg::idle: begin
				if (run) begin
					next_state = sync_pkg::desync;
					track_clr  = 1'b1;
				end
			end
			sync_pkg::desync: begin
				if (cnt_lead == npulse) begin
					next_state = sync_pkg::sync_lead;
					duty_clr   = 1'b1;
				end else if (cnt_slave == npulse) begin
					next_state = sync_pkg::sync_slave;
					duty_clr   = 1'b1;
				end
			end
			sync_pkg::sync_lead: begin
				if (cnt_duty > nduty) next_state = sync_pkg::check_lead;
			end
			sync_pkg::sync_slave: begin
				if (cnt_duty > nduty) next_state = sync_pkg::check_slave;
			end
			sync_pkg::check_lead: begin
				if (natural_rst) begin
					next_state = sync_pkg::sync_lead; // still the fastest
					duty_clr   = 1'b1;
				end else if (forced_rst) begin
					next_state = sync_pkg::desync;
					track_clr  = 1'b1;
				end
			end
			sync_pkg::check_slave: begin
				if (forced_rst) begin
					next_state = sync_pkg::sync_slave; // leader still there
					duty_clr   = 1'b1;
				end else if (natural_rst) begin
					next_state = sync_pkg::desync; // lost the leader
					track_clr  = 1'b1;
				end
			end
			default: next_state = sync_pkg::idle;
		endcase
	end

endmodule

`default_nettype wire

// File: pco/pco_core.sv
// pulse-coupled oscillator, counts phase on trigger ticks and fires on npco or on a late peak
`timescale 1ns/100ps
`default_nettype none

`include "pco_config.svh"

module pco_core (
	input  logic                 clk,
	input  logic                 greset_n,
	input  logic                 run,
	input  logic                 peak,       // async coupling peak
	input  logic                 design_sel, // forced reset restarts delay at 1
	input  sync_pkg::cnt_t       nblackout,
	input  sync_pkg::cnt_t       ncstr,
	input  sync_pkg::cnt_t       npco,
	input  sync_pkg::cnt_t       ndelay,
	output sync_pkg::pco_event_t ev
);

	logic [2:0]           peak_sync; // two sync flops plus previous sample
	sync_pkg::cnt_t       phase_q;
	logic [`CNTR_BITS:0]  phase_cstr; // one extra bit so the sum cannot wrap
	logic                 cpulse;
	logic                 cpulse_rst;
	logic                 tick;
	logic                 tick_rst;
	logic                 rst_forced;
	logic                 rst_natural;

	// rising edge of the synced peak, ignored inside the blackout
	assign cpulse = peak_sync[1] && !peak_sync[2] && (phase_q > nblackout);

	assign phase_cstr = {1'b0, phase_q} + {1'b0, ncstr};
	assign cpulse_rst = (phase_cstr >= {1'b0, npco});
	assign tick_rst   = (sync_pkg::cnt_t'(phase_q + 1'b1) == npco); // natural end of period

	assign rst_forced  = cpulse && cpulse_rst;
	assign rst_natural = tick && tick_rst;

	// event out, strobe bits straight from registered state
	assign ev.pulse  = rst_forced || rst_natural;
	assign ev.forced = rst_forced;
	assign ev.phase  = phase_q;

	always_ff @(posedge clk) begin
		if (!greset_n) begin
			peak_sync <= '0;
		end else if (run) begin
			peak_sync <= {peak_sync[1:0], peak};
		end
	end

	// phase counter starts at 1
	always_ff @(posedge clk) begin
		if (!greset_n) begin
			phase_q <= sync_pkg::cnt_t'(1);
		end else if (run) begin
			if (ev.pulse) begin
				phase_q <= sync_pkg::cnt_t'(1);
			end else if (cpulse) begin
				phase_q <= phase_q + ncstr; // coupling kick
			end else if (tick) begin
				phase_q <= phase_q + 1'b1;
			end
		end
	end

	pco_trigger u_trigger (
		.clk         (clk),
		.greset_n    (greset_n),
		.run         (run),
		.phase       (phase_q),
		.restart     (ev.pulse),
		.restart_one (design_sel && rst_forced),
		.ndelay      (ndelay),
		.tick        (tick)
	);

endmodule

`default_nettype wire

// File: pco/pco_trigger.sv
// delay and trigger counters of the pco, gives pco_core one tick per slowing trigger period
`timescale 1ns/100ps
`default_nettype none

module pco_trigger (
	input  logic           clk,
	input  logic           greset_n,
	input  logic           run,
	input  sync_pkg::cnt_t phase,       // current pco phase sets the trigger period
	input  logic           restart,     // pco reset this cycle
	input  logic           restart_one, // reload the delay counter with 1
	input  sync_pkg::cnt_t ndelay,
	output logic           tick
);

	sync_pkg::cnt_t cnt_del;  // initial delay after each pco reset
	sync_pkg::cnt_t cnt_trig; // divides by the current phase
	logic           del_done;
	logic           trig_wrap;

	assign del_done  = (cnt_del == ndelay);
	assign trig_wrap = (sync_pkg::cnt_t'(cnt_trig + 1'b1) == phase); // period grows with phase
	assign tick      = trig_wrap && del_done; // no ticks during the delay

	// delay counter, counts up once and holds at ndelay
	always_ff @(posedge clk) begin
		if (!greset_n) begin
			cnt_del <= '0;
		end else if (run) begin
			if (restart) begin
				cnt_del <= restart_one ? sync_pkg::cnt_t'(1) : '0; // design-select variant
			end else if (!del_done) begin
				cnt_del <= cnt_del + 1'b1;
			end
		end
	end

	// trigger counter, free running between wraps
	always_ff @(posedge clk) begin
		if (!greset_n) begin
			cnt_trig <= '0;
		end else if (run) begin
			if (restart || trig_wrap) begin
				cnt_trig <= '0;
			end else begin
				cnt_trig <= cnt_trig + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: common/sync_pkg.sv
// shared types of the pco sync node; modules reference them as sync_pkg::name
`default_nettype none

`include "pco_config.svh"

package sync_pkg;

	// phase count and all configured thresholds
	typedef logic [`CNTR_BITS-1:0] cnt_t;

	// duty-cycling controller states
	typedef enum logic [2:0] {
		idle        = 3'd0, // reset state, waits for run
		desync      = 3'd1, // tracking pco resets
		sync_lead   = 3'd2, // locked as the fastest node
		sync_slave  = 3'd3, // locked to a faster node
		check_lead  = 3'd4, // duty window off, confirm lead
		check_slave = 3'd5  // duty window off, confirm slave
	} ctrl_state_e;

	// one pco event per cycle, pulse is a single-cycle strobe
	typedef struct packed {
		logic pulse;  // pco resets this cycle
		logic forced; // reset came from a coupling peak
		cnt_t phase;  // registered phase count
	} pco_event_t;

	// encoded coupling sequence
	typedef logic [`SEQ_BITS-1:0] seq_t;

endpackage

`default_nettype wire

// File: common/pco_config.svh
// width settings for the pco sync node, included by the package and by modules using the widths
`ifndef PCO_CONFIG_SVH
`define PCO_CONFIG_SVH

// every pco/controller counter and threshold
`define CNTR_BITS 13

// encoded coupling sequence length, bit 0 goes out first
`define SEQ_BITS 64

// index into the encoded sequence
`define SEQ_IDX_BITS 6

`endif
